// File: hw/wb_pkg.sv
// Shared Wishbone classic bus, byte addressed, no byte selects or bursts, two masters only
`default_nettype none

package wb_pkg;

    // Byte address width of the CSR space
    // Covers 256 bytes, only a few of them implemented
    localparam int WB_ADR_W = 8;

    // Data word width, every access moves a full word
    localparam int WB_DAT_W = 32;

    // Masters sharing the bus through the round-robin arbiter
    // Arbiter logic is written for exactly two
    localparam int NUM_HOSTS = 2;

endpackage

`default_nettype wire

// File: hw/regmap_pkg.sv
// Register map for a 256-byte space, one register per 16-byte slot, offset must be zero
`default_nettype none

package regmap_pkg;

    // Implemented registers at 0x00, 0x10 ... 0xB0
    localparam int REG_COUNT = 12;

    // Upper address bits select the register slot
    localparam int REG_IDX_W = 4;

    // Lower address bits are the byte offset inside a slot
    localparam int REG_OFS_W = wb_pkg::WB_ADR_W - REG_IDX_W;

    // One address word, seen two ways
    // As the raw byte address on the bus side
    // As slot index and offset on the decode side
    typedef union packed {
        logic [wb_pkg::WB_ADR_W-1:0] byte_addr;
        struct packed {
            // Register slot
            logic [REG_IDX_W-1:0] index;
            // Nonzero means an unaligned access
            logic [REG_OFS_W-1:0] offset;
        } fields;
    } csr_addr_u;

endpackage

`default_nettype wire

// File: hw/sparse_regfile.sv
// Plain write and read ports, read is combinational, writes to unimplemented addresses are lost
`timescale 1ns/1ps
`default_nettype none

module sparse_regfile (
    input  logic                          clk,
    input  logic                          rst_n,

    // Write port, one word per enabled cycle
    input  logic                          write_en,
    input  regmap_pkg::csr_addr_u         write_addr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   write_data,

    // Read port, data follows the address in the same cycle
    input  regmap_pkg::csr_addr_u         read_addr,
    output logic [wb_pkg::WB_DAT_W-1:0]   read_data,
    output logic                          addr_valid
);

    // Storage only for the implemented slots
    logic [wb_pkg::WB_DAT_W-1:0] regs [regmap_pkg::REG_COUNT];

    // Write side hit on an implemented address
    logic wr_hit;

    // Implemented when aligned to the slot and inside the populated range
    function automatic logic is_impl(input regmap_pkg::csr_addr_u addr);
        return (addr.fields.offset == '0) &&
               (addr.fields.index < regmap_pkg::REG_COUNT);
    endfunction

    assign wr_hit     = is_impl(write_addr);
    assign addr_valid = is_impl(read_addr);

    // Read mux
    // Unimplemented addresses read as zero and never index past the array
    always_comb begin
        read_data = '0;
        if (addr_valid) begin
            read_data = regs[read_addr.fields.index];
        end
    end

    // Synchronous reset clears every register
    // Writes are dropped unless the address is implemented
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < regmap_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && wr_hit) begin
            regs[write_addr.fields.index] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_wb_slave.sv
// Single-cycle Wishbone classic slave, no byte selects or bursts, error status comes from regfile
`timescale 1ns/1ps
`default_nettype none

module csr_wb_slave (
    input  logic                          clk,
    input  logic                          rst_n,

    // Wishbone slave side, driven by the arbiter
    input  logic                          s_cyc,
    input  logic                          s_stb,
    input  logic                          s_we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   s_adr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   s_dat_w,
    output logic [wb_pkg::WB_DAT_W-1:0]   s_dat_r,
    output logic                          s_ack,
    output logic                          s_err,

    // Register file ports
    output logic                          write_en,
    output regmap_pkg::csr_addr_u         write_addr,
    output logic [wb_pkg::WB_DAT_W-1:0]   write_data,
    output regmap_pkg::csr_addr_u         read_addr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   read_data,
    input  logic                          addr_valid
);

    // First cycle of a strobe that has not been answered yet
    // The cycle with ack or err high is the master's last one, so it never retriggers
    logic new_req;

    assign new_req = s_cyc && s_stb && !s_ack && !s_err;

    // Both ports look at the bus address, the regfile does the decode
    assign write_addr.byte_addr = s_adr;
    assign read_addr.byte_addr  = s_adr;
    assign write_data           = s_dat_w;

    // One-cycle write pulse, lands on the same edge that raises ack
    assign write_en = new_req && s_we && addr_valid;

    // Response flags, exactly one cycle each
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_ack <= 1'b0;
            s_err <= 1'b0;
        end else begin
            s_ack <= new_req && addr_valid;
            s_err <= new_req && !addr_valid;
        end
    end

    // Read data captured with the response
    // Writes return zero, so do errored reads since the regfile gives zero
    always_ff @(posedge clk) begin
        if (new_req) begin
            s_dat_r <= s_we ? '0 : read_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/wb_rr_arbiter.sv
// Two-master Wishbone classic arbiter, grant held while cyc stays high, one idle cycle per handover
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,

    // Host A
    input  logic                          a_cyc,
    input  logic                          a_stb,
    input  logic                          a_we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   a_adr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   a_dat_w,
    output logic [wb_pkg::WB_DAT_W-1:0]   a_dat_r,
    output logic                          a_ack,
    output logic                          a_err,

    // Host B
    input  logic                          b_cyc,
    input  logic                          b_stb,
    input  logic                          b_we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   b_adr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   b_dat_w,
    output logic [wb_pkg::WB_DAT_W-1:0]   b_dat_r,
    output logic                          b_ack,
    output logic                          b_err,

    // Shared slave
    output logic                          s_cyc,
    output logic                          s_stb,
    output logic                          s_we,
    output logic [wb_pkg::WB_ADR_W-1:0]   s_adr,
    output logic [wb_pkg::WB_DAT_W-1:0]   s_dat_w,
    input  logic [wb_pkg::WB_DAT_W-1:0]   s_dat_r,
    input  logic                          s_ack,
    input  logic                          s_err
);

    // Bit 0 is host A, bit 1 is host B
    logic [wb_pkg::NUM_HOSTS-1:0] req;
    // One-hot grant, all zero when the bus is idle
    logic [wb_pkg::NUM_HOSTS-1:0] grant;
    // Host A was served last
    logic                         last_a;

    assign req = {b_cyc, a_cyc};

    // Grant FSM
    // Idle picks a host, a granted host keeps the bus until its cyc drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant  <= '0;
            last_a <= 1'b0;
        end else if (grant == '0) begin
            if (req == '1) begin
                // Contention, the host not served last wins, A first after reset
                grant  <= last_a ? 2'b10 : 2'b01;
                last_a <= !last_a;
            end else if (req[0]) begin
                grant  <= 2'b01;
                last_a <= 1'b1;
            end else if (req[1]) begin
                grant  <= 2'b10;
                last_a <= 1'b0;
            end
        end else if ((grant & req) == '0) begin
            // Owner finished, bus idles for one cycle
            grant <= '0;
        end
    end

    // Request mux, slave sees nothing while idle
    always_comb begin
        s_cyc   = 1'b0;
        s_stb   = 1'b0;
        s_we    = 1'b0;
        s_adr   = '0;
        s_dat_w = '0;
        if (grant[0]) begin
            s_cyc   = a_cyc;
            s_stb   = a_stb;
            s_we    = a_we;
            s_adr   = a_adr;
            s_dat_w = a_dat_w;
        end else if (grant[1]) begin
            s_cyc   = b_cyc;
            s_stb   = b_stb;
            s_we    = b_we;
            s_adr   = b_adr;
            s_dat_w = b_dat_w;
        end
    end

    // Responses reach only the granted host, data goes to both
    assign a_ack   = s_ack && grant[0];
    assign a_err   = s_err && grant[0];
    assign b_ack   = s_ack && grant[1];
    assign b_err   = s_err && grant[1];
    assign a_dat_r = s_dat_r;
    assign b_dat_r = s_dat_r;

endmodule

`default_nettype wire

// File: hw/csr_top.sv
// CSR block for two Wishbone classic hosts, 12 word registers at 0x00..0xB0, others answer err
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // Host A
    input  logic                          a_cyc,
    input  logic                          a_stb,
    input  logic                          a_we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   a_adr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   a_dat_w,
    output logic [wb_pkg::WB_DAT_W-1:0]   a_dat_r,
    output logic                          a_ack,
    output logic                          a_err,

    // Host B
    input  logic                          b_cyc,
    input  logic                          b_stb,
    input  logic                          b_we,
    input  logic [wb_pkg::WB_ADR_W-1:0]   b_adr,
    input  logic [wb_pkg::WB_DAT_W-1:0]   b_dat_w,
    output logic [wb_pkg::WB_DAT_W-1:0]   b_dat_r,
    output logic                          b_ack,
    output logic                          b_err
);

    // Granted bus between arbiter and adapter
    logic                          s_cyc;
    logic                          s_stb;
    logic                          s_we;
    logic [wb_pkg::WB_ADR_W-1:0]   s_adr;
    logic [wb_pkg::WB_DAT_W-1:0]   s_dat_w;
    logic [wb_pkg::WB_DAT_W-1:0]   s_dat_r;
    logic                          s_ack;
    logic                          s_err;

    // Regfile access
    logic                          write_en;
    regmap_pkg::csr_addr_u         write_addr;
    logic [wb_pkg::WB_DAT_W-1:0]   write_data;
    regmap_pkg::csr_addr_u         read_addr;
    logic [wb_pkg::WB_DAT_W-1:0]   read_data;
    logic                          addr_valid;

    wb_rr_arbiter i_wb_rr_arbiter (
        .clk     (clk),     .rst_n   (rst_n),
        .a_cyc   (a_cyc),   .a_stb   (a_stb),   .a_we    (a_we),
        .a_adr   (a_adr),   .a_dat_w (a_dat_w), .a_dat_r (a_dat_r),
        .a_ack   (a_ack),   .a_err   (a_err),
        .b_cyc   (b_cyc),   .b_stb   (b_stb),   .b_we    (b_we),
        .b_adr   (b_adr),   .b_dat_w (b_dat_w), .b_dat_r (b_dat_r),
        .b_ack   (b_ack),   .b_err   (b_err),
        .s_cyc   (s_cyc),   .s_stb   (s_stb),   .s_we    (s_we),
        .s_adr   (s_adr),   .s_dat_w (s_dat_w), .s_dat_r (s_dat_r),
        .s_ack   (s_ack),   .s_err   (s_err)
    );

    csr_wb_slave i_csr_wb_slave (
        .clk        (clk),        .rst_n      (rst_n),
        .s_cyc      (s_cyc),      .s_stb      (s_stb),      .s_we    (s_we),
        .s_adr      (s_adr),      .s_dat_w    (s_dat_w),    .s_dat_r (s_dat_r),
        .s_ack      (s_ack),      .s_err      (s_err),
        .write_en   (write_en),   .write_addr (write_addr), .write_data (write_data),
        .read_addr  (read_addr),  .read_data  (read_data),  .addr_valid (addr_valid)
    );

    sparse_regfile i_sparse_regfile (
        .clk        (clk),        .rst_n      (rst_n),
        .write_en   (write_en),   .write_addr (write_addr), .write_data (write_data),
        .read_addr  (read_addr),  .read_data  (read_data),  .addr_valid (addr_valid)
    );

endmodule

`default_nettype wire

// File: bench/csr_assertions.sv
// Bus protocol checks for the two-host arbiter, idle while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module csr_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         a_cyc,
    input logic                         b_cyc,
    input logic                         a_ack,
    input logic                         a_err,
    input logic                         b_ack,
    input logic                         b_err,
    input logic                         s_cyc,
    input logic                         s_ack,
    input logic                         s_err,
    input logic [wb_pkg::NUM_HOSTS-1:0] grant
);

    // Number of failed checks so far
    int fail_count = 0;

    // Slave answers with ack or err, never both, and only for one cycle
    ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        (s_ack || s_err) |-> !(s_ack && s_err) ##1 !(s_ack || s_err))
        else begin
            fail_count++;
            $error("s_ack and s_err did not form a single one-cycle response");
        end

    // Every slave response lands on a host that still holds its cycle open
    // A grant released too early would drop it
    resp_to_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (s_ack || s_err) |-> ((a_ack || a_err) && a_cyc) || ((b_ack || b_err) && b_cyc))
        else begin
            fail_count++;
            $error("slave response did not reach a host with an open cycle");
        end

    // A request on an idle bus reaches the slave on the next edge
    // Then s_cyc stays up through the two-cycle access
    cyc_follows_grant: assert property (@(posedge clk) disable iff (!rst_n)
        (grant == '0 && (a_cyc || b_cyc)) |=> s_cyc ##1 s_cyc)
        else begin
            fail_count++;
            $error("s_cyc does not follow the granted host");
        end

endmodule

// Port names match the arbiter's own signals
bind wb_rr_arbiter csr_assertions i_csr_assertions (.*);

`default_nettype wire

// File: bench/csr_checker.sv
// Compares each completed host cycle with the expected response, read data on reads only
`timescale 1ns/1ps
`default_nettype none

module csr_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we [wb_pkg::NUM_HOSTS],
    input  logic [wb_pkg::WB_DAT_W-1:0] dat_r [wb_pkg::NUM_HOSTS],
    input  logic                        ack [wb_pkg::NUM_HOSTS],
    input  logic                        err [wb_pkg::NUM_HOSTS],
    input  logic [wb_pkg::WB_DAT_W-1:0] exp_data [wb_pkg::NUM_HOSTS],
    input  logic                        exp_err [wb_pkg::NUM_HOSTS],
    output int                          done_count,
    output int                          error_count
);

    initial begin
        done_count  = 0;
        error_count = 0;
    end

    // Values just before the edge are the ones the host samples
    always @(posedge clk) begin
        if (rst_n) begin
            for (int h = 0; h < wb_pkg::NUM_HOSTS; h++) begin
                if (ack[h] || err[h]) begin
                    done_count++;
                    if (err[h] !== exp_err[h]) begin
                        error_count++;
                        $display("** Error at %0t ns: %s_err expected %0b, got %0b",
                                 $time, (h == 0) ? "a" : "b", exp_err[h], err[h]);
                    end
                    // Writes carry no read data
                    if (!we[h] && dat_r[h] !== exp_data[h]) begin
                        error_count++;
                        $display("** Error at %0t ns: %s_dat_r expected %h, got %h",
                                 $time, (h == 0) ? "a" : "b", exp_data[h], dat_r[h]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_csr_top.sv
// Run from the project root, stimulus rows hold one host cycle each, codes 2 and 3 are barriers
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

    // Six hex words per stimulus row
    localparam int ROW_W    = 6;
    localparam int MAX_ROWS = 64;
    localparam int PERIOD   = 40;

    logic clk   = 1'b0;
    logic rst_n = 1'b0;
    // Index 0 is host A, index 1 is host B, stb always travels with cyc
    logic                        cyc [wb_pkg::NUM_HOSTS] = '{default: 1'b0};
    logic                        we [wb_pkg::NUM_HOSTS] = '{default: 1'b0};
    logic [wb_pkg::WB_ADR_W-1:0] adr [wb_pkg::NUM_HOSTS] = '{default: '0};
    logic [wb_pkg::WB_DAT_W-1:0] dat_w [wb_pkg::NUM_HOSTS] = '{default: '0};
    logic [wb_pkg::WB_DAT_W-1:0] dat_r [wb_pkg::NUM_HOSTS];
    logic                        ack [wb_pkg::NUM_HOSTS];
    logic                        err [wb_pkg::NUM_HOSTS];
    // Expected response of the cycle each host has open
    logic [wb_pkg::WB_DAT_W-1:0] exp_data [wb_pkg::NUM_HOSTS] = '{default: '0};
    logic                        exp_err [wb_pkg::NUM_HOSTS] = '{default: 1'b0};
    logic [31:0]                 stim [ROW_W*MAX_ROWS];
    int                          row_count = 0;
    int                          bus_rows = 0;
    int                          done_count;
    int                          error_count;

    always #(PERIOD/2) clk = ~clk;

    csr_top i_csr_top (
        .clk     (clk),      .rst_n   (rst_n),
        .a_cyc   (cyc[0]),   .a_stb   (cyc[0]),   .a_we    (we[0]),    .a_adr   (adr[0]),
        .a_dat_w (dat_w[0]), .a_dat_r (dat_r[0]), .a_ack   (ack[0]),   .a_err   (err[0]),
        .b_cyc   (cyc[1]),   .b_stb   (cyc[1]),   .b_we    (we[1]),    .b_adr   (adr[1]),
        .b_dat_w (dat_w[1]), .b_dat_r (dat_r[1]), .b_ack   (ack[1]),   .b_err   (err[1])
    );

    csr_checker i_csr_checker (.*);

    // Ten cycles low, released 2 ns after an edge like every other input
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // Plays one host's rows between two barriers, one idle cycle between its cycles
    task automatic play_host_rows(input int h, input int first, input int last);
        for (int i = first; i < last; i++) begin
            if (stim[i*ROW_W] == h) begin
                @(posedge clk);
                #2;
                cyc[h]      = 1'b1;
                we[h]       = stim[i*ROW_W+1][0];
                adr[h]      = stim[i*ROW_W+2][wb_pkg::WB_ADR_W-1:0];
                dat_w[h]    = stim[i*ROW_W+3];
                exp_data[h] = stim[i*ROW_W+4];
                exp_err[h]  = stim[i*ROW_W+5][0];
                // Hold everything until ack or err is seen on an edge
                do begin
                    @(posedge clk);
                end while (!(ack[h] || err[h]));
                #2;
                cyc[h] = 1'b0;
            end
        end
    endtask

    initial begin
        int first;
        int last;
        foreach (stim[i]) begin
            stim[i] = 'x;
        end
        $readmemh("bench/csr_stim.txt", stim);
        // Rows end at the first word the file left unwritten
        while (row_count < MAX_ROWS && !$isunknown(stim[row_count*ROW_W])) begin
            bus_rows += (stim[row_count*ROW_W] < 2);
            row_count++;
        end
        if (row_count == 0) begin
            $display("No stimulus rows could be read from bench/csr_stim.txt");
        end
        apply_reset();
        first = 0;
        while (first < row_count) begin
            last = first;
            while (last < row_count && stim[last*ROW_W] < 2) begin
                last++;
            end
            // Both hosts start on the same edge, the arbiter settles who goes first
            fork
                play_host_rows(0, first, last);
                play_host_rows(1, first, last);
            join
            // Code 3 resets the DUT, code 2 only waits for both hosts
            if (last < row_count && stim[last*ROW_W] == 3) begin
                apply_reset();
            end
            first = last + 1;
        end
        $display("Cycles completed %0d of %0d, value errors %0d, assertion failures %0d",
                 done_count, bus_rows, error_count,
                 i_csr_top.i_wb_rr_arbiter.i_csr_assertions.fail_count);
        if (row_count > 0 && done_count == bus_rows && error_count == 0 &&
            i_csr_top.i_wb_rr_arbiter.i_csr_assertions.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Ten cycles per row plus the first reset, rows are counted by then
    initial begin
        #1;
        #((row_count * 10 + 10) * PERIOD);
        $display("Watchdog expired while a host was still waiting for ack or err");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/wb_pkg.sv
hw/regmap_pkg.sv
hw/sparse_regfile.sv
hw/csr_wb_slave.sv
hw/wb_rr_arbiter.sv
hw/csr_top.sv
bench/csr_assertions.sv
bench/csr_checker.sv
bench/tb_csr_top.sv

// File: bench/csr_stim.txt
// host we adr wdata rdata err in hex, host 0 is A, 1 is B, 2 waits for both, 3 resets
// rdata is compared on reads only, err 1 marks an access that must end in err
0 0 00 00000000 00000000 0
1 0 60 00000000 00000000 0
0 0 10 00000000 00000000 0
1 0 70 00000000 00000000 0
0 0 20 00000000 00000000 0
1 0 80 00000000 00000000 0
0 0 30 00000000 00000000 0
1 0 90 00000000 00000000 0
0 0 40 00000000 00000000 0
1 0 A0 00000000 00000000 0
0 0 50 00000000 00000000 0
1 0 B0 00000000 00000000 0
0 1 10 11112222 00000000 0
1 1 80 33334444 00000000 0
0 0 10 00000000 11112222 0
1 0 80 00000000 33334444 0
0 1 14 55555555 00000000 1
1 0 F0 00000000 00000000 1
0 0 10 00000000 11112222 0
0 1 50 CAFEF00D 00000000 0
2 0 00 00000000 00000000 0
1 0 50 00000000 CAFEF00D 0
3 0 00 00000000 00000000 0
0 0 10 00000000 00000000 0
1 0 80 00000000 00000000 0
